/* dv/mecobo_tb.sv */
// EBI host model with 8-cycle strobes; expected values follow the register map and waveform rules
`timescale 1ns/1ps
`default_nettype none

module mecobo_tb;

  localparam int NUM_PINS      = 4;
  localparam int STROBE_CYCLES = 8;
  localparam int IDLE_CYCLES   = 4;
  localparam int OE_TIMEOUT    = 16;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_CNT} op_t;

  // for OP_CNT addr is the pin index, wdata the window length and exp_val the high count
  typedef struct packed {
    op_t                       op;
    mecobo_bus_pkg::bus_addr_t addr;
    mecobo_bus_pkg::bus_word_t wdata;
    mecobo_bus_pkg::bus_word_t exp_val;
  } step_t;

  logic                      sys_clk;
  logic                      reset;
  logic                      ebi_cs_n;
  logic                      ebi_rd_n;
  logic                      ebi_wr_n;
  mecobo_bus_pkg::bus_addr_t ebi_addr;
  mecobo_bus_pkg::bus_word_t ebi_data_in;
  mecobo_bus_pkg::bus_word_t ebi_data_out;
  logic                      data_oe;
  logic                      led;
  logic [NUM_PINS-1:0]       pins;

  step_t       steps[$];
  int unsigned errors;
  int unsigned test_errors;
  int unsigned checks;
  int unsigned tests_run;
  int unsigned tests_failed;
  logic        timed_out;

  tb_clock_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (5)
  ) i_tb_clock_gen (
    .sys_clk (sys_clk),
    .reset   (reset)
  );

  mecobo_core #(
    .NUM_PINS (NUM_PINS)
  ) i_mecobo_core (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .ebi_cs_n     (ebi_cs_n),
    .ebi_rd_n     (ebi_rd_n),
    .ebi_wr_n     (ebi_wr_n),
    .ebi_addr     (ebi_addr),
    .ebi_data_in  (ebi_data_in),
    .ebi_data_out (ebi_data_out),
    .data_oe      (data_oe),
    .led          (led),
    .pins         (pins)
  );

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("%0t: timeout, %s", $time, what);
    timed_out = 1'b1;
    note_error();
  endtask

  // inputs change 2 ns after the edge
  task automatic next_cycle();
    @(posedge sys_clk);
    #2;
  endtask

  task automatic check_word(input string what, input mecobo_bus_pkg::bus_word_t got,
                            input mecobo_bus_pkg::bus_word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      note_error();
    end
  endtask

  // counts high samples of one pin over a window of consecutive cycles
  task automatic check_pin(input int idx, input int unsigned cycles, input int unsigned exp_high);
    int unsigned high;
    logic        level;
    high = 0;
    for (int unsigned c = 0; c < cycles; c++) begin
      next_cycle();
      level = pins[idx];
      if (level === 1'b1) begin
        high++;
      end
    end
    checks++;
    if (high != exp_high) begin
      $display("Mismatch at %0t: pin %0d high %0d of %0d cycles, expected %0d",
               $time, idx, high, cycles, exp_high);
      note_error();
    end
  endtask

  // heartbeat top bit stays low for the first 2^23 cycles after reset
  task automatic check_led_low(input int unsigned cycles);
    int unsigned high;
    high = 0;
    for (int unsigned c = 0; c < cycles; c++) begin
      next_cycle();
      if (led !== 1'b0) begin
        high++;
      end
    end
    checks++;
    if (high != 0) begin
      $display("Mismatch at %0t: led not low in %0d of %0d cycles after reset",
               $time, high, cycles);
      note_error();
    end
  endtask

  task automatic check_oe_idle();
    checks++;
    if (data_oe !== 1'b0) begin
      $display("Mismatch at %0t: data_oe high outside a read", $time);
      note_error();
    end
  endtask

  task automatic ebi_write(input mecobo_bus_pkg::bus_addr_t addr,
                           input mecobo_bus_pkg::bus_word_t data);
    next_cycle();
    check_oe_idle();
    ebi_addr    = addr;
    ebi_data_in = data;
    ebi_cs_n    = 1'b0;
    ebi_wr_n    = 1'b0;
    for (int c = 0; c < STROBE_CYCLES; c++) begin
      next_cycle();
    end
    ebi_cs_n = 1'b1;
    ebi_wr_n = 1'b1;
    // sync stages and edge detect settle before the next strobe
    for (int c = 0; c < IDLE_CYCLES; c++) begin
      next_cycle();
    end
  endtask

  task automatic ebi_read(input mecobo_bus_pkg::bus_addr_t addr,
                          output mecobo_bus_pkg::bus_word_t data);
    int waited;
    next_cycle();
    check_oe_idle();
    ebi_addr = addr;
    ebi_cs_n = 1'b0;
    ebi_rd_n = 1'b0;
    waited   = 0;
    while (!data_oe && waited < OE_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!data_oe) begin
      report_timeout("data_oe never rose during a read");
    end
    // hold the strobe for the full 8 cycles, sample in the last
    while (waited < STROBE_CYCLES) begin
      next_cycle();
      waited++;
    end
    data     = ebi_data_out;
    ebi_cs_n = 1'b1;
    ebi_rd_n = 1'b1;
    waited   = 0;
    while (data_oe && waited < OE_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (data_oe) begin
      report_timeout("data_oe still high after the read strobe was released");
    end
    for (int c = 0; c < IDLE_CYCLES; c++) begin
      next_cycle();
    end
  endtask

  function automatic mecobo_bus_pkg::bus_addr_t reg_addr(input int pin, input int off);
    return mecobo_bus_pkg::bus_addr_t'(int'(mecobo_bus_pkg::PIN_BASE)
                                       + pin * int'(mecobo_bus_pkg::PIN_STRIDE) + off);
  endfunction

  // high cycles over 8 periods
  function automatic int unsigned pwm_high(input int unsigned period, input int unsigned duty);
    return ((duty < period) ? duty : period) * 8;
  endfunction

  function automatic int unsigned square_high(input int unsigned period);
    return (period / 2) * 8;
  endfunction

  task automatic write_step(input mecobo_bus_pkg::bus_addr_t addr,
                            input mecobo_bus_pkg::bus_word_t data);
    steps.push_back('{op: OP_WR, addr: addr, wdata: data, exp_val: 16'h0000});
  endtask

  task automatic read_step(input mecobo_bus_pkg::bus_addr_t addr,
                           input mecobo_bus_pkg::bus_word_t exp);
    steps.push_back('{op: OP_RD, addr: addr, wdata: 16'h0000, exp_val: exp});
  endtask

  task automatic count_step(input int pin, input int unsigned cycles, input int unsigned high);
    steps.push_back('{op: OP_CNT, addr: mecobo_bus_pkg::bus_addr_t'(pin),
                      wdata: mecobo_bus_pkg::bus_word_t'(cycles),
                      exp_val: mecobo_bus_pkg::bus_word_t'(high)});
  endtask

  task automatic apply_steps();
    mecobo_bus_pkg::bus_word_t rd;
    foreach (steps[i]) begin
      if (!timed_out) begin
        case (steps[i].op)
          OP_WR: ebi_write(steps[i].addr, steps[i].wdata);
          OP_RD: begin
            ebi_read(steps[i].addr, rd);
            check_word($sformatf("addr %h", steps[i].addr), rd, steps[i].exp_val);
          end
          default: check_pin(int'(steps[i].addr), int'(steps[i].wdata), int'(steps[i].exp_val));
        endcase
      end
    end
    steps.delete();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic test_reset_values();
    for (int p = 0; p < NUM_PINS; p++) begin
      for (int off = 0; off < 6; off++) begin
        read_step(reg_addr(p, off), 16'h0000);
      end
    end
    for (int p = 0; p < NUM_PINS; p++) begin
      count_step(p, 100, 0);
    end
    apply_steps();
    check_led_low(100);
    finish_test("reset_values");
  endtask

  // with period 0 the pin is low, so REG_LAST reads 0
  task automatic test_read_only_regs();
    for (int p = 0; p < NUM_PINS; p++) begin
      write_step(reg_addr(p, int'(mecobo_pin_pkg::REG_PERIOD)), 16'h0000);
      write_step(reg_addr(p, int'(mecobo_pin_pkg::REG_TICK)),
                 mecobo_bus_pkg::bus_word_t'($urandom));
      write_step(reg_addr(p, int'(mecobo_pin_pkg::REG_LAST)),
                 mecobo_bus_pkg::bus_word_t'($urandom));
      read_step(reg_addr(p, int'(mecobo_pin_pkg::REG_TICK)), 16'h0000);
      read_step(reg_addr(p, int'(mecobo_pin_pkg::REG_TICK)), 16'h0000);
      read_step(reg_addr(p, int'(mecobo_pin_pkg::REG_LAST)), 16'h0000);
    end
    apply_steps();
    finish_test("read_only_regs");
  endtask

  // all windows written before any is read back, so overlap shows up
  task automatic test_register_readback();
    mecobo_pin_pkg::reg_off_t  offs[4];
    mecobo_bus_pkg::bus_word_t vals[NUM_PINS][4];
    offs = '{mecobo_pin_pkg::REG_WAVE, mecobo_pin_pkg::REG_PERIOD,
             mecobo_pin_pkg::REG_DUTY, mecobo_pin_pkg::REG_SPARE};
    for (int p = 0; p < NUM_PINS; p++) begin
      for (int k = 0; k < 4; k++) begin
        vals[p][k] = mecobo_bus_pkg::bus_word_t'($urandom);
        write_step(reg_addr(p, int'(offs[k])), vals[p][k]);
      end
    end
    for (int p = 0; p < NUM_PINS; p++) begin
      for (int k = 0; k < 4; k++) begin
        read_step(reg_addr(p, int'(offs[k])), vals[p][k]);
      end
    end
    apply_steps();
    finish_test("register_readback");
  endtask

  task automatic program_pin(input int p, input mecobo_pin_pkg::waveform_t wave,
                             input int unsigned period, input int unsigned duty);
    write_step(reg_addr(p, int'(mecobo_pin_pkg::REG_WAVE)), mecobo_bus_pkg::bus_word_t'(wave));
    write_step(reg_addr(p, int'(mecobo_pin_pkg::REG_DUTY)), mecobo_bus_pkg::bus_word_t'(duty));
    write_step(reg_addr(p, int'(mecobo_pin_pkg::REG_PERIOD)),
               mecobo_bus_pkg::bus_word_t'(period));
  endtask

  task automatic test_waveforms();
    int unsigned pa;
    int unsigned da;
    int unsigned pb;
    int unsigned pc;
    pa = $urandom_range(20, 2);
    da = $urandom_range(pa - 1, 1);
    pb = $urandom_range(20, 2);
    pc = $urandom_range(20, 2);
    program_pin(0, mecobo_pin_pkg::WAVE_PWM, pa, da);
    program_pin(1, mecobo_pin_pkg::WAVE_SQUARE, pb, 0);
    // duty past period gives a constant high
    program_pin(2, mecobo_pin_pkg::WAVE_PWM, pc, pc + 3);
    program_pin(3, mecobo_pin_pkg::WAVE_TRI, 10, 5);
    count_step(0, pa * 8, pwm_high(pa, da));
    count_step(1, pb * 8, square_high(pb));
    count_step(2, pc * 8, pwm_high(pc, pc + 3));
    count_step(3, 80, 0);
    read_step(reg_addr(2, int'(mecobo_pin_pkg::REG_LAST)), 16'h0001);
    write_step(reg_addr(0, int'(mecobo_pin_pkg::REG_WAVE)),
               mecobo_bus_pkg::bus_word_t'(mecobo_pin_pkg::WAVE_OFF));
    count_step(0, pa * 8, 0);
    apply_steps();
    finish_test("waveforms");
  endtask

  task automatic test_status_words();
    read_step(mecobo_bus_pkg::STATUS_ID_ADDR, 16'h4D43);
    read_step(mecobo_bus_pkg::STATUS_PINS_ADDR, 16'(NUM_PINS));
    read_step(19'h7FFFF, 16'h0000);
    read_step(19'h00002, 16'h0000);
    // first word past the last pin window
    read_step(reg_addr(NUM_PINS, 0), 16'h0000);
    apply_steps();
    finish_test("status_words");
  endtask

  initial begin
    int waited;
    ebi_cs_n     = 1'b1;
    ebi_rd_n     = 1'b1;
    ebi_wr_n     = 1'b1;
    ebi_addr     = 19'h00000;
    ebi_data_in  = 16'h0000;
    errors       = 0;
    test_errors  = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    void'($urandom(67479));
    waited = 0;
    while (reset !== 1'b0 && waited < 20) begin
      next_cycle();
      waited++;
    end
    if (reset !== 1'b0) begin
      report_timeout("reset was never released");
    end
    test_reset_values();
    test_read_only_regs();
    test_register_readback();
    test_waveforms();
    test_status_words();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// free running testbench clock; reset is held high for the first RESET_CYCLES rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic sys_clk,
  output logic reset
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
  end

  // released just after an edge, like the other stimulus
  initial begin
    reset = 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge sys_clk);
    end
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* flist.f */
verilog/mecobo_bus_pkg.sv
verilog/mecobo_pin_pkg.sv
verilog/ebi_front.sv
verilog/pin_controller.sv
verilog/board_status.sv
verilog/mecobo_core.sv
dv/tb_clock_gen.sv
dv/mecobo_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs mecobo_tb with Verilator; the result is read from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mecobo_tb \
  -Mdir obj_dir -o mecobo_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mecobo_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi

if ! grep -q "TEST OK" sim.log; then
  echo "no pass message found in sim.log"
  exit 1
fi

exit 0

/* verilog/board_status.sv */
// heartbeat led toggles every 2^23 sys_clk cycles; status words are read only, writes are ignored
`timescale 1ns/1ps
`default_nettype none

module board_status #(
  parameter int NUM_PINS = 4
) (
  input  wire                       sys_clk,
  input  wire                       reset,
  input  mecobo_bus_pkg::bus_req_t  bus_req,
  output mecobo_bus_pkg::bus_word_t rdata,
  output logic                      led
);

  // free running heartbeat
  logic [23:0] heartbeat;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      heartbeat <= '0;
    end else begin
      heartbeat <= heartbeat + 24'd1;
    end
  end

  assign led = heartbeat[23];

  // identification and pin count
  always_comb begin
    rdata = '0;
    if (bus_req.rd) begin
      if (bus_req.addr == mecobo_bus_pkg::STATUS_ID_ADDR) begin
        rdata = mecobo_bus_pkg::BOARD_ID;
      end else if (bus_req.addr == mecobo_bus_pkg::STATUS_PINS_ADDR) begin
        rdata = mecobo_bus_pkg::bus_word_t'(NUM_PINS);
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/ebi_front.sv */
// EBI strobes are async; host must hold addr and data stable while a strobe is low
`timescale 1ns/1ps
`default_nettype none

module ebi_front #(
  parameter int NUM_PINS = 4
) (
  input  wire                                          sys_clk,
  input  wire                                          reset,
  input  wire                                          ebi_cs_n,
  input  wire                                          ebi_rd_n,
  input  wire                                          ebi_wr_n,
  input  mecobo_bus_pkg::bus_addr_t                    ebi_addr,
  input  mecobo_bus_pkg::bus_word_t                    ebi_data_in,
  input  mecobo_bus_pkg::bus_word_t [NUM_PINS-1:0]     pin_rdata,
  input  mecobo_bus_pkg::bus_word_t                    status_rdata,
  output mecobo_bus_pkg::bus_req_t                     bus_req,
  output mecobo_bus_pkg::bus_word_t                    ebi_data_out,
  output logic                                         data_oe
);

  // two-stage synchronizers, held active high
  logic [1:0] cs_sync;
  logic [1:0] rd_sync;
  logic [1:0] wr_sync;

  // strobe already turned into a request
  logic wr_seen;
  logic rd_seen;

  logic cs_active;
  logic wr_active;
  logic rd_active;

  mecobo_bus_pkg::bus_addr_t addr_q;
  mecobo_bus_pkg::bus_word_t wdata_q;
  mecobo_bus_pkg::bus_word_t rd_or;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cs_sync <= 2'b00;
      rd_sync <= 2'b00;
      wr_sync <= 2'b00;
      wr_seen <= 1'b0;
      rd_seen <= 1'b0;
    end else begin
      cs_sync <= {cs_sync[0], ~ebi_cs_n};
      rd_sync <= {rd_sync[0], ~ebi_rd_n};
      wr_sync <= {wr_sync[0], ~ebi_wr_n};
      wr_seen <= wr_active;
      rd_seen <= rd_active;
    end
  end

  // address and data are stable by the time the strobe is through both stages
  always_ff @(posedge sys_clk) begin
    addr_q  <= ebi_addr;
    wdata_q <= ebi_data_in;
  end

  assign cs_active = cs_sync[1];
  assign wr_active = cs_active & wr_sync[1];
  assign rd_active = cs_active & rd_sync[1];

  assign bus_req.addr  = addr_q;
  assign bus_req.wdata = wdata_q;
  assign bus_req.wr    = wr_active & ~wr_seen;
  assign bus_req.rd    = rd_active & ~rd_seen;

  // blocks return zero when not addressed
  always_comb begin
    rd_or = status_rdata;
    for (int i = 0; i < NUM_PINS; i++) begin
      rd_or = rd_or | pin_rdata[i];
    end
  end

  // read word held until the next read
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      ebi_data_out <= '0;
    end else if (bus_req.rd) begin
      ebi_data_out <= rd_or;
    end
  end

  assign data_oe = rd_active;

  // chip select must have crossed both sync stages before the bus is driven
  a_oe_needs_cs: assert property (@(posedge sys_clk) disable iff (reset)
    data_oe |-> cs_active && $past(cs_sync[0]));

  a_wr_rd_excl: assert property (@(posedge sys_clk) disable iff (reset)
    !(bus_req.wr && bus_req.rd));

endmodule

`default_nettype wire

/* verilog/mecobo_bus_pkg.sv */
// EBI word and address types and the word address map; word addressing only, no byte lanes
`default_nettype none

package mecobo_bus_pkg;

  // one data word on the external bus
  typedef logic [15:0] bus_word_t;

  // word address as seen on ebi_addr
  typedef logic [18:0] bus_addr_t;

  // one-cycle request seen by every register block
  typedef struct packed {
    bus_addr_t addr;
    bus_word_t wdata;
    logic      wr;
    logic      rd;
  } bus_req_t;

  // pin windows start here, one window per pin
  localparam bus_addr_t PIN_BASE = 19'h00032;

  // words per pin window
  localparam int unsigned PIN_STRIDE = 6;

  // board status words
  localparam bus_addr_t STATUS_ID_ADDR = 19'h00000;
  localparam bus_addr_t STATUS_PINS_ADDR = 19'h00001;

  // identification word, ascii "MC"
  localparam bus_word_t BOARD_ID = 16'h4D43;

endpackage

`default_nettype wire

/* verilog/mecobo_core.sv */
// pin-controller core; data bus split into in/out/oe, tristate buffer belongs in a board wrapper
`timescale 1ns/1ps
`default_nettype none

module mecobo_core #(
  parameter int NUM_PINS = 4
) (
  input  wire                       sys_clk,
  input  wire                       reset,
  input  wire                       ebi_cs_n,
  input  wire                       ebi_rd_n,
  input  wire                       ebi_wr_n,
  input  mecobo_bus_pkg::bus_addr_t ebi_addr,
  input  mecobo_bus_pkg::bus_word_t ebi_data_in,
  output mecobo_bus_pkg::bus_word_t ebi_data_out,
  output logic                      data_oe,
  output logic                      led,
  output logic [NUM_PINS-1:0]       pins
);

  mecobo_bus_pkg::bus_req_t                    bus_req;
  mecobo_bus_pkg::bus_word_t [NUM_PINS-1:0]    pin_rdata;
  mecobo_bus_pkg::bus_word_t                   status_rdata;

  ebi_front #(
    .NUM_PINS (NUM_PINS)
  ) i_ebi_front (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .ebi_cs_n     (ebi_cs_n),
    .ebi_rd_n     (ebi_rd_n),
    .ebi_wr_n     (ebi_wr_n),
    .ebi_addr     (ebi_addr),
    .ebi_data_in  (ebi_data_in),
    .pin_rdata    (pin_rdata),
    .status_rdata (status_rdata),
    .bus_req      (bus_req),
    .ebi_data_out (ebi_data_out),
    .data_oe      (data_oe)
  );

  board_status #(
    .NUM_PINS (NUM_PINS)
  ) i_board_status (
    .sys_clk (sys_clk),
    .reset   (reset),
    .bus_req (bus_req),
    .rdata   (status_rdata),
    .led     (led)
  );

  // one window per pin, consecutive from PIN_BASE
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    pin_controller #(
      .PIN_INDEX (i)
    ) i_pin_controller (
      .sys_clk (sys_clk),
      .reset   (reset),
      .bus_req (bus_req),
      .rdata   (pin_rdata[i]),
      .pin     (pins[i])
    );
  end

endmodule

`default_nettype wire

/* verilog/mecobo_pin_pkg.sv */
// pin window layout and waveform codes; saw and triangle codes are stored but drive the pin low
`default_nettype none

package mecobo_pin_pkg;

  // waveform select, full word so any written value reads back
  typedef enum logic [15:0] {
    WAVE_OFF    = 16'd0,
    WAVE_SQUARE = 16'd1,
    WAVE_SAW    = 16'd2,
    WAVE_TRI    = 16'd3,
    WAVE_PWM    = 16'd4
  } waveform_t;

  // word offset inside a pin window
  typedef logic [2:0] reg_off_t;

  localparam reg_off_t REG_WAVE = 3'd0;
  localparam reg_off_t REG_PERIOD = 3'd1;
  localparam reg_off_t REG_DUTY = 3'd2;
  // read only, live counter
  localparam reg_off_t REG_TICK = 3'd3;
  // read only, registered pin level
  localparam reg_off_t REG_LAST = 3'd4;
  localparam reg_off_t REG_SPARE = 3'd5;

  // host programmed settings of one pin
  typedef struct packed {
    waveform_t                 wave;
    mecobo_bus_pkg::bus_word_t period;
    mecobo_bus_pkg::bus_word_t duty;
  } pin_cfg_t;

endpackage

`default_nettype wire

/* verilog/pin_controller.sv */
// one pin window of six words; saw and triangle codes drive the pin low, period 0 stops the pin
`timescale 1ns/1ps
`default_nettype none

module pin_controller #(
  parameter int PIN_INDEX = 0
) (
  input  wire                       sys_clk,
  input  wire                       reset,
  input  mecobo_bus_pkg::bus_req_t  bus_req,
  output mecobo_bus_pkg::bus_word_t rdata,
  output logic                      pin
);

  localparam mecobo_bus_pkg::bus_addr_t WIN_BASE = mecobo_bus_pkg::bus_addr_t'(
    mecobo_bus_pkg::PIN_BASE + PIN_INDEX * mecobo_bus_pkg::PIN_STRIDE);
  localparam mecobo_bus_pkg::bus_addr_t WIN_END = mecobo_bus_pkg::bus_addr_t'(
    WIN_BASE + mecobo_bus_pkg::PIN_STRIDE);

  mecobo_pin_pkg::pin_cfg_t  cfg;
  mecobo_bus_pkg::bus_word_t spare;
  mecobo_bus_pkg::bus_word_t tick;
  mecobo_bus_pkg::bus_addr_t addr_diff;
  mecobo_pin_pkg::reg_off_t  reg_off;
  mecobo_bus_pkg::bus_word_t rd_word;
  logic                      hit;
  logic                      period_wr;
  logic                      level_next;

  // window decode
  assign hit       = (bus_req.addr >= WIN_BASE) && (bus_req.addr < WIN_END);
  assign addr_diff = bus_req.addr - WIN_BASE;
  assign reg_off   = addr_diff[2:0];
  assign period_wr = bus_req.wr && hit && (reg_off == mecobo_pin_pkg::REG_PERIOD);

  // host writes; tick and last are read only
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cfg   <= '0;
      spare <= '0;
    end else if (bus_req.wr && hit) begin
      case (reg_off)
        mecobo_pin_pkg::REG_WAVE:   cfg.wave <= mecobo_pin_pkg::waveform_t'(bus_req.wdata);
        mecobo_pin_pkg::REG_PERIOD: cfg.period <= bus_req.wdata;
        mecobo_pin_pkg::REG_DUTY:   cfg.duty <= bus_req.wdata;
        mecobo_pin_pkg::REG_SPARE:  spare <= bus_req.wdata;
        default: ;
      endcase
    end
  end

  // counts 0 .. period-1, restarts on a period write
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      tick <= '0;
    end else if (period_wr || (cfg.period == '0)) begin
      tick <= '0;
    end else if (tick == cfg.period - 16'd1) begin
      tick <= '0;
    end else begin
      tick <= tick + 16'd1;
    end
  end

  always_comb begin
    level_next = 1'b0;
    if (cfg.period != '0) begin
      case (cfg.wave)
        mecobo_pin_pkg::WAVE_SQUARE: level_next = tick < (cfg.period >> 1);
        // duty at or above period gives constant high
        mecobo_pin_pkg::WAVE_PWM:    level_next = tick < cfg.duty;
        default:                     level_next = 1'b0;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      pin <= 1'b0;
    end else begin
      pin <= level_next;
    end
  end

  // read word, zero when not addressed
  always_comb begin
    case (reg_off)
      mecobo_pin_pkg::REG_WAVE:   rd_word = mecobo_bus_pkg::bus_word_t'(cfg.wave);
      mecobo_pin_pkg::REG_PERIOD: rd_word = cfg.period;
      mecobo_pin_pkg::REG_DUTY:   rd_word = cfg.duty;
      mecobo_pin_pkg::REG_TICK:   rd_word = tick;
      mecobo_pin_pkg::REG_LAST:   rd_word = mecobo_bus_pkg::bus_word_t'(pin);
      mecobo_pin_pkg::REG_SPARE:  rd_word = spare;
      default:                    rd_word = '0;
    endcase
  end

  assign rdata = (bus_req.rd && hit) ? rd_word : '0;

  // period changes only together with a tick clear
  a_tick_in_range: assert property (@(posedge sys_clk) disable iff (reset)
    (cfg.period != '0) |-> (tick < cfg.period));

endmodule

`default_nettype wire
